// File: hart_pkg.sv
`default_nettype none

package hart_pkg;

  localparam int XLEN = 32;  // data and address width of the hart

  // a data word, also used for addresses and instruction words
  typedef logic [XLEN-1:0] word_t;

  typedef logic [4:0] reg_addr_t;  // index into x0..x31

  // major opcode field, bits [6:0] of every instruction
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,  // register-register alu ops
    OPC_OP_IMM = 7'b0010011,  // register-immediate alu ops
    OPC_LUI    = 7'b0110111,  // load upper immediate
    OPC_AUIPC  = 7'b0010111,  // add upper immediate to pc
    OPC_JAL    = 7'b1101111,  // jump and link, pc relative
    OPC_JALR   = 7'b1100111,  // jump and link, register relative
    OPC_BRANCH = 7'b1100011,  // the six conditional branches
    OPC_LOAD   = 7'b0000011,  // only lw is carried out
    OPC_STORE  = 7'b0100011,  // only sw is carried out
    OPC_SYSTEM = 7'b1110011   // ebreak lives here, the rest is a no-op
  } opcode_e;

  // operations of the execute-stage alu
  typedef enum logic [3:0] {
    ALU_ADD,   // also used for address and jalr target math
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT,   // signed compare, result is 0 or 1
    ALU_SLTU,  // unsigned compare, result is 0 or 1
    ALU_SLL,
    ALU_SRL,
    ALU_SRA    // shift right keeping the sign bit
  } alu_op_e;

  // where the register write data comes from
  typedef enum logic [1:0] {
    WB_ALU,  // alu result, for alu ops and auipc
    WB_MEM,  // data memory read word, for lw
    WB_PC4,  // link address, for jal and jalr
    WB_IMM   // the u immediate as is, for lui
  } wb_sel_e;

  // the only system instruction the hart acts on, it halts the hart
  localparam word_t EBREAK_INST = 32'h0010_0073;

endpackage

`default_nettype wire

// File: hart_ctrl_if.sv
`default_nettype none

// decoded control and operands of the instruction in flight
interface hart_ctrl_if import hart_pkg::*; ();

  opcode_e    opcode;     // major opcode, raw value kept for unknown codes
  alu_op_e    alu_op;     // what the alu does with its operands
  logic [2:0] funct3;     // raw funct3, picks the branch condition
  word_t      rs1_data;   // register file read data for rs1
  word_t      rs2_data;   // register file read data for rs2, also store data
  word_t      imm;        // immediate already built for the opcode's format
  reg_addr_t  rd_addr;    // destination register field
  logic       reg_write;  // instruction writes rd
  wb_sel_e    wb_sel;     // source of the rd write data
  logic       mem_read;   // lw
  logic       mem_write;  // sw
  logic       is_halt;    // ebreak

  // decode produces every field
  modport dec_mp (
    output opcode, alu_op, funct3, rs1_data, rs2_data, imm,
           rd_addr, reg_write, wb_sel, mem_read, mem_write, is_halt
  );

  // execute needs the operands and what to do with them
  modport exe_mp (
    input opcode, alu_op, funct3, rs1_data, rs2_data, imm, is_halt
  );

  // result drives memory and the register write
  modport res_mp (
    input rs2_data, imm, rd_addr, reg_write, wb_sel, mem_read, mem_write, is_halt
  );

endinterface

`default_nettype wire

// File: hart_regfile.sv
`default_nettype none

module hart_regfile import hart_pkg::*; (
  input  logic      i_clk,
  input  logic      i_rst,
  input  reg_addr_t i_rs1_addr,  // first read port
  input  reg_addr_t i_rs2_addr,  // second read port
  output word_t     o_rs1_data,
  output word_t     o_rs2_data,
  input  reg_addr_t i_rd_addr,   // write port, x0 is dropped
  input  logic      i_rd_wen,
  input  word_t     i_rd_data
);

  // x1..x31, x0 has no storage and reads as zero
  word_t regs [1:31];

  // reads are combinational, a write shows up after the next edge
  assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      // the whole file starts at zero so programs see known values
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_rd_wen && (i_rd_addr != '0)) begin
      regs[i_rd_addr] <= i_rd_data;  // writes to x0 fall through here
    end
  end

endmodule

`default_nettype wire

// File: hart_decode.sv
`default_nettype none

module hart_decode import hart_pkg::*; (
  input  word_t          i_inst,       // instruction word from imem, same cycle
  output reg_addr_t      o_rs1_addr,   // to the register file
  output reg_addr_t      o_rs2_addr,
  input  word_t          i_rs1_rdata,  // back from the register file
  input  word_t          i_rs2_rdata,
  hart_ctrl_if.dec_mp    ctrl
);

  opcode_e    opc;        // major opcode seen through the enum
  logic [2:0] funct3;
  logic       funct7_b5;  // sub/sra select, bit 30 of the word
  logic       is_word;    // funct3 says word access for load and store
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;
  alu_op_e    alu_funct;  // alu op named by funct3 and funct7
  alu_op_e    alu_op;
  wb_sel_e    wb_sel;
  word_t      imm;
  logic       reg_write;
  logic       mem_read;
  logic       mem_write;

  assign opc       = opcode_e'(i_inst[6:0]);  // unknown codes keep their raw value
  assign funct3    = i_inst[14:12];
  assign funct7_b5 = i_inst[30];
  assign is_word   = (funct3 == 3'b010);

  assign o_rs1_addr = i_inst[19:15];
  assign o_rs2_addr = i_inst[24:20];

  // immediates for each format, all sign extended from bit 31
  assign imm_i = {{20{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{20{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{19{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {i_inst[31:12], 12'd0};
  assign imm_j = {{11{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // funct3 names the op for both OP and OP_IMM
  always_comb begin
    case (funct3)
      3'b000:  alu_funct = (opc == OPC_OP && funct7_b5) ? ALU_SUB : ALU_ADD;  // addi has no sub
      3'b001:  alu_funct = ALU_SLL;
      3'b010:  alu_funct = ALU_SLT;
      3'b011:  alu_funct = ALU_SLTU;
      3'b100:  alu_funct = ALU_XOR;
      3'b101:  alu_funct = funct7_b5 ? ALU_SRA : ALU_SRL;  // srai also has bit 30 set
      3'b110:  alu_funct = ALU_OR;
      default: alu_funct = ALU_AND;
    endcase
  end

  always_comb begin
    // defaults describe a no-op, any opcode not listed below keeps them
    alu_op    = ALU_ADD;
    wb_sel    = WB_ALU;
    imm       = imm_i;
    reg_write = 1'b0;
    mem_read  = 1'b0;
    mem_write = 1'b0;
    case (opc)
      OPC_OP, OPC_OP_IMM: begin
        alu_op    = alu_funct;
        reg_write = 1'b1;
      end
      OPC_LUI: begin
        imm       = imm_u;
        wb_sel    = WB_IMM;
        reg_write = 1'b1;
      end
      OPC_AUIPC: begin
        imm       = imm_u;  // added to pc in the alu
        reg_write = 1'b1;
      end
      OPC_JAL: begin
        imm       = imm_j;
        wb_sel    = WB_PC4;
        reg_write = 1'b1;
      end
      OPC_JALR: begin
        wb_sel    = WB_PC4;  // target is rs1 + imm_i from the alu
        reg_write = 1'b1;
      end
      OPC_BRANCH: imm = imm_b;
      OPC_LOAD: begin
        wb_sel    = WB_MEM;
        reg_write = is_word;  // lb, lh and friends are dropped as no-ops
        mem_read  = is_word;
      end
      OPC_STORE: begin
        imm       = imm_s;
        mem_write = is_word;
      end
      default: ;
    endcase
  end

  // a store never writes rd, so a store can't also update the register file
  always_comb begin
    a_no_reg_and_mem_write: assert final (!(reg_write && mem_write))
      else $error("decode set both reg_write and mem_write for inst %h", i_inst);
  end

  assign ctrl.opcode    = opc;
  assign ctrl.alu_op    = alu_op;
  assign ctrl.funct3    = funct3;
  assign ctrl.rs1_data  = i_rs1_rdata;
  assign ctrl.rs2_data  = i_rs2_rdata;
  assign ctrl.imm       = imm;
  assign ctrl.rd_addr   = i_inst[11:7];
  assign ctrl.reg_write = reg_write;
  assign ctrl.wb_sel    = wb_sel;
  assign ctrl.mem_read  = mem_read;
  assign ctrl.mem_write = mem_write;
  assign ctrl.is_halt   = (i_inst == EBREAK_INST);

endmodule

`default_nettype wire

// File: hart_execute.sv
`default_nettype none

module hart_execute import hart_pkg::*; #(
  parameter word_t RESET_ADDR = '0  // first fetch address, word aligned
) (
  input  logic               i_clk,
  input  logic               i_rst,
  hart_ctrl_if.exe_mp        ctrl,
  output word_t              o_pc,          // fetch address of this cycle
  output word_t              o_pc_plus4,    // link value and fall-through target
  output word_t              o_next_pc,
  output word_t              o_alu_result,
  output logic               o_retire_en    // this cycle's instruction takes effect
);

  word_t pc;
  logic  halted;     // set by a retired ebreak, cleared only by reset
  logic  retire_en;
  word_t op_a;
  word_t op_b;
  word_t alu_res;
  word_t pc_plus4;
  word_t pc_target;  // pc relative target for jal and branches
  word_t next_pc;
  logic  br_cond;

  assign retire_en = !i_rst && !halted;
  assign pc_plus4  = pc + 32'd4;
  assign pc_target = pc + ctrl.imm;

  // operand a is pc for auipc and zero for lui, operand b is rs2 only for OP
  always_comb begin
    case (ctrl.opcode)
      OPC_AUIPC: op_a = pc;
      OPC_LUI:   op_a = '0;
      default:   op_a = ctrl.rs1_data;
    endcase
    op_b = (ctrl.opcode == OPC_OP) ? ctrl.rs2_data : ctrl.imm;
  end

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:  alu_res = op_a + op_b;
      ALU_SUB:  alu_res = op_a - op_b;
      ALU_AND:  alu_res = op_a & op_b;
      ALU_OR:   alu_res = op_a | op_b;
      ALU_XOR:  alu_res = op_a ^ op_b;
      ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_SLL:  alu_res = op_a << op_b[4:0];  // only the low five bits shift
      ALU_SRL:  alu_res = op_a >> op_b[4:0];
      ALU_SRA:  alu_res = $signed(op_a) >>> op_b[4:0];
      default:  alu_res = op_a + op_b;
    endcase
  end

  // branch condition straight from funct3, rs1 against rs2
  always_comb begin
    case (ctrl.funct3)
      3'b000:  br_cond = (ctrl.rs1_data == ctrl.rs2_data);                  // beq
      3'b001:  br_cond = (ctrl.rs1_data != ctrl.rs2_data);                  // bne
      3'b100:  br_cond = ($signed(ctrl.rs1_data) < $signed(ctrl.rs2_data));  // blt
      3'b101:  br_cond = ($signed(ctrl.rs1_data) >= $signed(ctrl.rs2_data)); // bge
      3'b110:  br_cond = (ctrl.rs1_data < ctrl.rs2_data);                   // bltu
      3'b111:  br_cond = (ctrl.rs1_data >= ctrl.rs2_data);                  // bgeu
      default: br_cond = 1'b0;  // 010 and 011 are not branches
    endcase
  end

  always_comb begin
    case (ctrl.opcode)
      OPC_JAL:    next_pc = pc_target;
      OPC_JALR:   next_pc = {alu_res[XLEN-1:1], 1'b0};  // rs1 + imm with bit 0 cleared
      OPC_BRANCH: next_pc = br_cond ? pc_target : pc_plus4;
      default:    next_pc = pc_plus4;
    endcase
  end

  // pc and halted move together, nothing changes once halted
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      pc     <= RESET_ADDR;
      halted <= 1'b0;
    end else if (retire_en) begin
      pc     <= next_pc;
      halted <= ctrl.is_halt;  // ebreak freezes the hart from the next cycle
    end
  end

  a_pc_aligned: assert property (@(posedge i_clk) disable iff (i_rst) pc[1:0] == 2'b00)
    else $error("pc %h is not word aligned", pc);

  assign o_pc         = pc;
  assign o_pc_plus4   = pc_plus4;
  assign o_next_pc    = next_pc;
  assign o_alu_result = alu_res;
  assign o_retire_en  = retire_en;

endmodule

`default_nettype wire

// File: hart_result.sv
`default_nettype none

module hart_result import hart_pkg::*; (
  hart_ctrl_if.res_mp ctrl,
  input  logic      i_retire_en,      // low in reset and once halted
  input  word_t     i_inst,
  input  word_t     i_pc,
  input  word_t     i_pc_plus4,
  input  word_t     i_next_pc,
  input  word_t     i_alu_result,     // also the data memory address
  input  word_t     i_dmem_rdata,
  output word_t     o_dmem_addr,
  output word_t     o_dmem_wdata,
  output logic      o_dmem_ren,
  output logic      o_dmem_wen,
  output reg_addr_t o_rd_waddr,       // to the register file
  output logic      o_rd_wen,
  output word_t     o_rd_wdata,
  output logic      o_retire_valid,
  output logic      o_retire_halt,
  output word_t     o_retire_inst,
  output word_t     o_retire_pc,
  output word_t     o_retire_next_pc,
  output reg_addr_t o_retire_rd_waddr,
  output word_t     o_retire_rd_wdata
);

  word_t     wb_data;
  reg_addr_t rd_waddr;

  // memory sees the address every cycle, the enables only when retiring
  assign o_dmem_addr  = i_alu_result;
  assign o_dmem_wdata = ctrl.rs2_data;  // sw stores rs2 whole
  assign o_dmem_ren   = ctrl.mem_read && i_retire_en;
  assign o_dmem_wen   = ctrl.mem_write && i_retire_en;

  always_comb begin
    case (ctrl.wb_sel)
      WB_ALU:  wb_data = i_alu_result;
      WB_MEM:  wb_data = i_dmem_rdata;  // valid since ren is high for lw
      WB_PC4:  wb_data = i_pc_plus4;
      default: wb_data = ctrl.imm;      // lui
    endcase
  end

  // the memory only takes one kind of access per cycle
  always_comb begin
    a_dmem_ren_wen_excl: assert final (!(o_dmem_ren && o_dmem_wen))
      else $error("data memory read and write enabled together at pc %h", i_pc);
  end

  assign rd_waddr   = ctrl.reg_write ? ctrl.rd_addr : '0;  // stores and branches report x0
  assign o_rd_waddr = rd_waddr;
  assign o_rd_wen   = ctrl.reg_write && i_retire_en;
  assign o_rd_wdata = wb_data;

  assign o_retire_valid    = i_retire_en;
  assign o_retire_halt     = ctrl.is_halt && i_retire_en;
  assign o_retire_inst     = i_inst;
  assign o_retire_pc       = i_pc;
  assign o_retire_next_pc  = i_next_pc;
  assign o_retire_rd_waddr = rd_waddr;
  assign o_retire_rd_wdata = wb_data;

endmodule

`default_nettype wire

// File: hart.sv
`default_nettype none

module hart import hart_pkg::*; #(
  parameter word_t RESET_ADDR = 32'h0000_0000  // pc after reset
) (
  input  logic      i_clk,
  input  logic      i_rst,              // synchronous, active high
  output word_t     o_imem_raddr,       // fetch address, word aligned
  input  word_t     i_imem_rdata,       // instruction returned in the same cycle
  output word_t     o_dmem_addr,
  output logic      o_dmem_ren,         // read data comes back combinationally
  output logic      o_dmem_wen,         // write lands at the next rising edge
  output word_t     o_dmem_wdata,
  input  word_t     i_dmem_rdata,
  output logic      o_retire_valid,     // one instruction retires per cycle
  output logic      o_retire_halt,
  output word_t     o_retire_inst,
  output word_t     o_retire_pc,
  output word_t     o_retire_next_pc,
  output word_t     o_retire_rd_wdata,
  output reg_addr_t o_retire_rd_waddr   // zero when nothing is written
);

  word_t     pc;
  word_t     pc_plus4;
  word_t     next_pc;
  word_t     alu_result;
  logic      retire_en;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  word_t     rs1_rdata;
  word_t     rs2_rdata;
  reg_addr_t rd_waddr;
  logic      rd_wen;
  word_t     rd_wdata;

  hart_ctrl_if u_ctrl ();  // decode to execute and result

  assign o_imem_raddr = pc;

  hart_decode u_decode (
    .i_inst      (i_imem_rdata),
    .o_rs1_addr  (rs1_addr),
    .o_rs2_addr  (rs2_addr),
    .i_rs1_rdata (rs1_rdata),
    .i_rs2_rdata (rs2_rdata),
    .ctrl        (u_ctrl.dec_mp)
  );

  hart_regfile u_regfile (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_rs1_addr (rs1_addr),
    .i_rs2_addr (rs2_addr),
    .o_rs1_data (rs1_rdata),
    .o_rs2_data (rs2_rdata),
    .i_rd_addr  (rd_waddr),
    .i_rd_wen   (rd_wen),
    .i_rd_data  (rd_wdata)
  );

  hart_execute #(
    .RESET_ADDR (RESET_ADDR)
  ) u_execute (
    .i_clk        (i_clk),
    .i_rst        (i_rst),
    .ctrl         (u_ctrl.exe_mp),
    .o_pc         (pc),
    .o_pc_plus4   (pc_plus4),
    .o_next_pc    (next_pc),
    .o_alu_result (alu_result),
    .o_retire_en  (retire_en)
  );

  hart_result u_result (
    .ctrl              (u_ctrl.res_mp),
    .i_retire_en       (retire_en),
    .i_inst            (i_imem_rdata),
    .i_pc              (pc),
    .i_pc_plus4        (pc_plus4),
    .i_next_pc         (next_pc),
    .i_alu_result      (alu_result),
    .i_dmem_rdata      (i_dmem_rdata),
    .o_dmem_addr       (o_dmem_addr),
    .o_dmem_wdata      (o_dmem_wdata),
    .o_dmem_ren        (o_dmem_ren),
    .o_dmem_wen        (o_dmem_wen),
    .o_rd_waddr        (rd_waddr),
    .o_rd_wen          (rd_wen),
    .o_rd_wdata        (rd_wdata),
    .o_retire_valid    (o_retire_valid),
    .o_retire_halt     (o_retire_halt),
    .o_retire_inst     (o_retire_inst),
    .o_retire_pc       (o_retire_pc),
    .o_retire_next_pc  (o_retire_next_pc),
    .o_retire_rd_waddr (o_retire_rd_waddr),
    .o_retire_rd_wdata (o_retire_rd_wdata)
  );

endmodule

`default_nettype wire

// File: tb_hart_prog.svh
`ifndef TB_HART_PROG_SVH
`define TB_HART_PROG_SVH

int prog_idx;  // next free instruction slot

function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3,
                                      input logic [4:0] rd);
  return {f7, rs2, rs1, f3, rd, 7'h33};
endfunction

function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                      input logic [2:0] f3, input logic [4:0] rd,
                                      input logic [6:0] op);
  return {imm, rs1, f3, rd, op};
endfunction

function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1);
  return {imm[11:5], rs2, rs1, 3'd2, imm[4:0], 7'h23};
endfunction

function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                      input logic [4:0] rs1, input logic [2:0] f3);
  return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
endfunction

function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
  return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
endfunction

task automatic put(input logic [31:0] w);
  imem[prog_idx] = w;
  prog_idx++;
endtask

task automatic load_program();
  for (int i = 0; i < 64; i++) begin
    imem[i] = enc_i(12'(i), 5'd0, 3'd0, 5'd0, 7'h13);  // addi x0,x0,i as filler
    dmem[i] = $random(seed);
    exp_mem[i] = dmem[i];
  end
  prog_idx = RESET_ADDR / 4;  // the program starts at the reset address
  put({20'h12345, 5'd1, 7'h37});               // lui x1
  put(enc_i(12'hff9, 5'd0, 3'd0, 5'd2, 7'h13)); // x2 = -7
  put(enc_i(12'd5, 5'd0, 3'd0, 5'd3, 7'h13));   // x3 = 5
  put(enc_r(7'h00, 5'd3, 5'd2, 3'd0, 5'd4));    // add
  put(enc_r(7'h20, 5'd2, 5'd3, 3'd0, 5'd5));    // sub
  put(enc_r(7'h00, 5'd2, 5'd1, 3'd7, 5'd6));    // and
  put(enc_r(7'h00, 5'd3, 5'd2, 3'd6, 5'd7));    // or
  put(enc_r(7'h00, 5'd3, 5'd1, 3'd4, 5'd8));    // xor
  put(enc_r(7'h00, 5'd3, 5'd2, 3'd2, 5'd9));    // slt
  put(enc_r(7'h00, 5'd3, 5'd2, 3'd3, 5'd10));   // sltu
  put(enc_r(7'h00, 5'd3, 5'd3, 3'd1, 5'd11));   // sll
  put(enc_r(7'h00, 5'd3, 5'd2, 3'd5, 5'd12));   // srl
  put(enc_r(7'h20, 5'd3, 5'd2, 3'd5, 5'd13));   // sra
  put(enc_i(12'h402, 5'd2, 3'd5, 5'd14, 7'h13)); // srai by 2
  put(enc_i(12'd6, 5'd3, 3'd3, 5'd15, 7'h13));  // sltiu
  put({20'h00001, 5'd18, 7'h17});               // auipc
  put(enc_s(12'd8, 5'd1, 5'd0));                // sw x1, 8(x0)
  put(enc_i(12'd8, 5'd0, 3'd2, 5'd19, 7'h03));  // lw it back
  put(enc_i(12'd16, 5'd0, 3'd2, 5'd20, 7'h03)); // lw a seeded word
  put(enc_i(12'd55, 5'd0, 3'd0, 5'd0, 7'h13));  // write to x0 is dropped
  put(enc_r(7'h00, 5'd0, 5'd0, 3'd0, 5'd21));   // x0 still reads zero
  put(enc_b(13'd8, 5'd3, 5'd3, 3'd0));          // beq taken
  put(enc_i(12'd1, 5'd0, 3'd0, 5'd22, 7'h13));  // skipped
  put(enc_b(13'd8, 5'd3, 5'd3, 3'd1));          // bne not taken
  put(enc_b(13'd8, 5'd3, 5'd2, 3'd4));          // blt taken
  put(enc_i(12'd2, 5'd0, 3'd0, 5'd22, 7'h13));  // skipped
  put(enc_b(13'd8, 5'd3, 5'd2, 3'd5));          // bge not taken
  put(enc_b(13'd8, 5'd3, 5'd2, 3'd6));          // bltu not taken
  put(enc_b(13'd8, 5'd3, 5'd2, 3'd7));          // bgeu taken
  put(enc_i(12'd3, 5'd0, 3'd0, 5'd22, 7'h13));  // skipped
  put(enc_j(21'd8, 5'd23));                     // jal over one slot
  put(enc_i(12'd4, 5'd0, 3'd0, 5'd22, 7'h13));  // skipped
  put(enc_i(12'((prog_idx + 3) * 4), 5'd0, 3'd0, 5'd24, 7'h13));
  put(enc_i(12'd1, 5'd24, 3'd0, 5'd25, 7'h67)); // jalr, bit 0 of target cleared
  put(enc_i(12'd5, 5'd0, 3'd0, 5'd22, 7'h13));  // skipped
  put(32'h0010_0073);                           // ebreak
endtask

`endif

// File: tb_hart.sv
`default_nettype none

module tb_hart;

  localparam logic [31:0] RESET_ADDR = 32'h0000_0040;  // first fetch, the program is placed there
  localparam int HALF_PERIOD = 10;       // 20 time unit clock
  localparam int HALT_TIMEOUT = 500;     // cycles allowed for the program to reach ebreak
  localparam int POST_HALT_CYCLES = 20;

  logic        i_clk;
  logic        i_rst;
  logic [31:0] o_imem_raddr;
  logic [31:0] i_imem_rdata;
  logic [31:0] o_dmem_addr;
  logic        o_dmem_ren;
  logic        o_dmem_wen;
  logic [31:0] o_dmem_wdata;
  logic [31:0] i_dmem_rdata;
  logic        o_retire_valid;
  logic        o_retire_halt;
  logic [31:0] o_retire_inst;
  logic [31:0] o_retire_pc;
  logic [31:0] o_retire_next_pc;
  logic [31:0] o_retire_rd_wdata;
  logic [4:0]  o_retire_rd_waddr;

  logic [31:0] imem [0:63];     // instruction memory, word indexed
  logic [31:0] dmem [0:63];     // data memory as the DUT sees it
  logic [31:0] exp_mem [0:63];  // expected data memory contents
  logic [31:0] sregs [0:31];    // shadow register file
  int          seed = 32'hd0a66722;
  int          n_errors = 0;
  int          n_checks = 0;
  int          n_timeouts = 0;
  int          cycles;
  logic        halt_seen = 1'b0;
  logic        first_seen = 1'b0;
  logic [31:0] prev_next_pc;

  `include "tb_hart_prog.svh"

  hart #(
    .RESET_ADDR (RESET_ADDR)
  ) u_dut (
    .i_clk             (i_clk),
    .i_rst             (i_rst),
    .o_imem_raddr      (o_imem_raddr),
    .i_imem_rdata      (i_imem_rdata),
    .o_dmem_addr       (o_dmem_addr),
    .o_dmem_ren        (o_dmem_ren),
    .o_dmem_wen        (o_dmem_wen),
    .o_dmem_wdata      (o_dmem_wdata),
    .i_dmem_rdata      (i_dmem_rdata),
    .o_retire_valid    (o_retire_valid),
    .o_retire_halt     (o_retire_halt),
    .o_retire_inst     (o_retire_inst),
    .o_retire_pc       (o_retire_pc),
    .o_retire_next_pc  (o_retire_next_pc),
    .o_retire_rd_wdata (o_retire_rd_wdata),
    .o_retire_rd_waddr (o_retire_rd_waddr)
  );

  initial i_clk = 1'b0;
  always #HALF_PERIOD i_clk = ~i_clk;

  // both memories answer in the same cycle, the data memory writes on the edge
  assign i_imem_rdata = imem[o_imem_raddr[7:2]];
  assign i_dmem_rdata = dmem[o_dmem_addr[7:2]];

  always @(posedge i_clk) begin
    if (o_dmem_wen) begin
      dmem[o_dmem_addr[7:2]] <= o_dmem_wdata;
    end
  end

  task automatic report_error(input string msg);
    $display("[ERROR] t=%0t %s", $time, msg);
    n_errors++;
  endtask

  // reference alu, straight from the ISA description of funct3 and bit 30
  function automatic logic [31:0] ref_alu(input logic [2:0] f3, input logic sub_sra,
                                          input logic is_reg, input logic [31:0] a,
                                          input logic [31:0] b);
    case (f3)
      3'd0:    return (is_reg && sub_sra) ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return {31'd0, $signed(a) < $signed(b)};
      3'd3:    return {31'd0, a < b};
      3'd4:    return a ^ b;
      3'd5:    return sub_sra ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic logic [31:0] imm_i(input logic [31:0] w);
    return {{20{w[31]}}, w[31:20]};
  endfunction

  function automatic logic [31:0] imm_b(input logic [31:0] w);
    return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
  endfunction

  function automatic logic [31:0] imm_j(input logic [31:0] w);
    return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
  endfunction

  function automatic logic writes_rd(input logic [31:0] w);
    case (w[6:0])
      7'h33, 7'h13, 7'h37, 7'h17, 7'h6f, 7'h67: return 1'b1;
      7'h03:   return (w[14:12] == 3'd2);  // only lw is carried out
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] ref_wdata(input logic [31:0] w, input logic [31:0] pc);
    logic [31:0] a;
    logic [31:0] b;
    a = sregs[w[19:15]];
    b = sregs[w[24:20]];
    case (w[6:0])
      7'h33:   return ref_alu(w[14:12], w[30], 1'b1, a, b);
      7'h13:   return ref_alu(w[14:12], w[30], 1'b0, a, imm_i(w));
      7'h37:   return {w[31:12], 12'd0};
      7'h17:   return pc + {w[31:12], 12'd0};
      7'h6f, 7'h67: return pc + 32'd4;  // link address
      default: return exp_mem[6'((a + imm_i(w)) >> 2)];
    endcase
  endfunction

  function automatic logic [31:0] ref_next_pc(input logic [31:0] w, input logic [31:0] pc);
    logic [31:0] a;
    logic [31:0] b;
    logic        take;
    a = sregs[w[19:15]];
    b = sregs[w[24:20]];
    case (w[14:12])
      3'd0:    take = (a == b);
      3'd1:    take = (a != b);
      3'd4:    take = ($signed(a) < $signed(b));
      3'd5:    take = ($signed(a) >= $signed(b));
      3'd6:    take = (a < b);
      default: take = (a >= b);
    endcase
    case (w[6:0])
      7'h6f:   return pc + imm_j(w);
      7'h67:   return (a + imm_i(w)) & ~32'd1;
      7'h63:   return take ? pc + imm_b(w) : pc + 32'd4;
      default: return pc + 32'd4;
    endcase
  endfunction

  task automatic check_retire();
    logic [31:0] w;
    logic [31:0] exp_wd;
    logic [31:0] st_addr;
    logic        is_lw;
    logic        is_sw;
    w = o_retire_inst;
    exp_wd = ref_wdata(w, o_retire_pc);
    is_lw = (w[6:0] == 7'h03) && (w[14:12] == 3'd2);
    is_sw = (w[6:0] == 7'h23) && (w[14:12] == 3'd2);
    n_checks++;
    if (!first_seen) begin
      a_first_pc: assert (o_retire_pc == RESET_ADDR)
        else report_error($sformatf("first retire pc %h, expected %h", o_retire_pc, RESET_ADDR));
    end else begin
      a_pc_chain: assert (o_retire_pc == prev_next_pc)
        else report_error($sformatf("retire pc %h, expected %h", o_retire_pc, prev_next_pc));
    end
    // the retiring word is the one fetched from the retiring pc in this cycle
    a_fetch: assert (o_imem_raddr == o_retire_pc
                     && w == imem[o_retire_pc[7:2]])
      else report_error($sformatf("retire pc %h inst %h, fetch address %h", o_retire_pc, w,
                                  o_imem_raddr));
    a_dmem_en: assert (o_dmem_ren == is_lw && o_dmem_wen == is_sw)
      else report_error($sformatf("inst %h dmem ren %b wen %b", w, o_dmem_ren, o_dmem_wen));
    a_next_pc: assert (o_retire_next_pc == ref_next_pc(w, o_retire_pc))
      else report_error($sformatf("inst %h next_pc %h, expected %h", w, o_retire_next_pc,
                                  ref_next_pc(w, o_retire_pc)));
    if (writes_rd(w)) begin
      a_rd_addr: assert (o_retire_rd_waddr == w[11:7])
        else report_error($sformatf("inst %h rd_waddr %0d", w, o_retire_rd_waddr));
      a_rd_data: assert (o_retire_rd_wdata == exp_wd)
        else report_error($sformatf("inst %h rd_wdata %h, expected %h", w, o_retire_rd_wdata,
                                    exp_wd));
      if (w[11:7] != 5'd0) sregs[w[11:7]] = exp_wd;  // x0 stays zero in the model
    end else begin
      a_rd_zero: assert (o_retire_rd_waddr == 5'd0)
        else report_error($sformatf("inst %h reports rd_waddr %0d", w, o_retire_rd_waddr));
    end
    if (w[6:0] == 7'h23) begin
      st_addr = sregs[w[19:15]] + {{20{w[31]}}, w[31:25], w[11:7]};
      a_store: assert (o_dmem_wen && o_dmem_addr == st_addr
                       && o_dmem_wdata == sregs[w[24:20]])
        else report_error($sformatf("sw at %h drove addr %h data %h", st_addr, o_dmem_addr,
                                    o_dmem_wdata));
      exp_mem[st_addr[7:2]] = sregs[w[24:20]];
    end
    a_halt_flag: assert (o_retire_halt == (w == 32'h0010_0073))
      else report_error($sformatf("inst %h retire_halt %b", w, o_retire_halt));
    if (w == 32'h0010_0073) halt_seen = 1'b1;
    first_seen = 1'b1;
    prev_next_pc = o_retire_next_pc;
  endtask

  // outputs are settled mid cycle, so every check runs on the falling edge
  always @(negedge i_clk) begin
    if (i_rst) begin
      a_reset_quiet: assert (!o_retire_valid && !o_dmem_ren && !o_dmem_wen)
        else report_error("retire or dmem enable high during reset");
    end else if (halt_seen) begin
      a_stay_halted: assert (!o_retire_valid && !o_dmem_ren && !o_dmem_wen)
        else report_error("hart still active after ebreak");
    end else if (o_retire_valid) begin
      check_retire();
    end
  end

  initial begin
    i_rst = 1'b1;
    for (int i = 0; i < 32; i++) sregs[i] = 32'd0;
    load_program();
    repeat (8) @(posedge i_clk);
    #2 i_rst = 1'b0;
    cycles = 0;
    while (!halt_seen && cycles < HALT_TIMEOUT) begin  // run until ebreak retires
      @(posedge i_clk);
      cycles++;
    end
    if (!halt_seen) begin
      $display("timeout: the program never halted within %0d cycles", HALT_TIMEOUT);
      n_timeouts++;
    end else begin
      repeat (POST_HALT_CYCLES) @(posedge i_clk);
    end
    $display("retired %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
    if (n_errors == 0 && n_timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: filelist.f
+incdir+.
hart_pkg.sv
hart_ctrl_if.sv
hart_regfile.sv
hart_decode.sv
hart_execute.sv
hart_result.sv
hart.sv
tb_hart.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f filelist.f --top-module tb_hart -o tb_hart_sim

out=$(./obj_dir/tb_hart_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Simulation PASSED"; then
  exit 0
else
  exit 1
fi
